// File: run.sh
#!/bin/sh
# Build and run the MFCC sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
        --top-module tb_mfcc_ctrl -f vlog.f -o sim_mfcc_ctrl

out=$(./obj_dir/sim_mfcc_ctrl)
echo "$out"
echo "$out" | grep -qx "All checks passed"

// File: src/frame_counter.sv
module frame_counter import mfcc_pkg::*; #(
        parameter int NUM_FRAMES = DEF_NUM_FRAMES
) (
        input  logic clk,
        input  logic rst_n,
        input  logic clear,
        input  logic advance,
        output logic final_frame
);

        localparam int IDX_W = (NUM_FRAMES > 1) ? $clog2(NUM_FRAMES) : 1;

        logic [IDX_W-1:0] idx;

        assign final_frame = (idx == IDX_W'(NUM_FRAMES - 1));

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        idx <= '0;
                end else if (clear) begin
                        idx <= '0;                      // New run starts at frame zero
                end else if (advance && !final_frame) begin
                        idx <= idx + 1'b1;
                end
        end

endmodule

// File: src/mfcc_ctrl_top.sv
module mfcc_ctrl_top import mfcc_pkg::*; #(
        parameter int WAIT_LEN   = DEF_WAIT_LEN,
        parameter int DELTA_LEN  = DEF_DELTA_LEN,
        parameter int DELTA2_LEN = DEF_DELTA2_LEN,
        parameter int ENERGY_LEN = DEF_ENERGY_LEN,
        parameter int NUM_FRAMES = DEF_NUM_FRAMES,
        parameter int LEN_W      = CNT_W
) (
        input  logic        clk,
        input  logic        rst_n,
        input  logic        start,
        output logic        preem_en,
        output logic        window_en,
        output logic        fft_en,
        output logic        amp_en,
        output logic        mel_en,
        output logic        cep_en,
        output logic        delta_en,
        output logic        delta2_en,
        output logic        energy_copy_en,
        output logic        pw_swap,
        output logic        wf_swap,
        output logic        fa_swap,
        output logic        am_swap,
        output logic        mc_swap,
        output result_sel_e result_sel,
        output logic        done
);

        logic             run;
        logic [LEN_W-1:0] len;
        logic             last;
        logic             clear;
        logic             advance;
        logic             final_frame;
        seq_state_e       state;

        step_timer #(
                .LEN_W (LEN_W)
        ) i_step_timer (
                .clk   (clk),
                .rst_n (rst_n),
                .run   (run),
                .len   (len),
                .last  (last)
        );

        frame_counter #(
                .NUM_FRAMES (NUM_FRAMES)
        ) i_frame_counter (
                .clk         (clk),
                .rst_n       (rst_n),
                .clear       (clear),
                .advance     (advance),
                .final_frame (final_frame)
        );

        mfcc_sequencer #(
                .LEN_W      (LEN_W),
                .WAIT_LEN   (WAIT_LEN),
                .ENERGY_LEN (ENERGY_LEN),
                .DELTA_LEN  (DELTA_LEN),
                .DELTA2_LEN (DELTA2_LEN)
        ) i_mfcc_sequencer (
                .clk         (clk),
                .rst_n       (rst_n),
                .start       (start),
                .last        (last),
                .final_frame (final_frame),
                .run         (run),
                .len         (len),
                .clear       (clear),
                .advance     (advance),
                .state       (state)
        );

        stage_decoder i_stage_decoder (
                .state          (state),
                .preem_en       (preem_en),
                .window_en      (window_en),
                .fft_en         (fft_en),
                .amp_en         (amp_en),
                .mel_en         (mel_en),
                .cep_en         (cep_en),
                .delta_en       (delta_en),
                .delta2_en      (delta2_en),
                .energy_copy_en (energy_copy_en),
                .pw_swap        (pw_swap),
                .wf_swap        (wf_swap),
                .fa_swap        (fa_swap),
                .am_swap        (am_swap),
                .mc_swap        (mc_swap),
                .result_sel     (result_sel),
                .done           (done)
        );

endmodule

// File: src/mfcc_pkg.sv
package mfcc_pkg;

        localparam int CNT_W          = 20;
        localparam int DEF_WAIT_LEN   = 400000;
        localparam int DEF_DELTA_LEN  = 70000;
        localparam int DEF_DELTA2_LEN = 70000;
        localparam int DEF_ENERGY_LEN = 1000;
        localparam int DEF_NUM_FRAMES = 100;

        typedef enum logic [4:0] {
                IDLE,
                PRE,            // Pipeline fill
                P_W,
                P_W_F,
                P_W_F_A,
                P_W_F_A_M,
                FULL,           // All six stages busy
                W_F_A_M_C,      // Pipeline drain
                F_A_M_C,
                A_M_C,
                M_C,
                CEP,
                WAIT_FILL,
                WAIT_LOOP,
                WAIT_DRAIN,
                WAIT_CEP,
                BRANCH,
                NEXT_FRAME,
                ENERGY,
                DELTA,
                DELTA2,
                FINISH
        } seq_state_e;

        typedef enum logic [2:0] {
                RES_NONE   = 3'd0,
                RES_ENERGY = 3'd1,
                RES_CEP    = 3'd2,
                RES_DELTA  = 3'd3,
                RES_DELTA2 = 3'd4
        } result_sel_e;

endpackage

// File: src/mfcc_sequencer.sv
module mfcc_sequencer import mfcc_pkg::*; #(
        parameter int LEN_W      = CNT_W,
        parameter int WAIT_LEN   = DEF_WAIT_LEN,
        parameter int ENERGY_LEN = DEF_ENERGY_LEN,
        parameter int DELTA_LEN  = DEF_DELTA_LEN,
        parameter int DELTA2_LEN = DEF_DELTA2_LEN
) (
        input  logic             clk,
        input  logic             rst_n,
        input  logic             start,
        input  logic             last,
        input  logic             final_frame,
        output logic             run,
        output logic [LEN_W-1:0] len,
        output logic             clear,
        output logic             advance,
        output seq_state_e       state
);

        seq_state_e state_nxt;
        seq_state_e resume;             // Where the current wait returns to
        logic       active;

        // State that follows the wait after an active pipeline step
        function automatic seq_state_e follow(seq_state_e s);
                case (s)
                        PRE:       return P_W;
                        P_W:       return P_W_F;
                        P_W_F:     return P_W_F_A;
                        P_W_F_A:   return P_W_F_A_M;
                        P_W_F_A_M: return FULL;
                        FULL:      return BRANCH;
                        W_F_A_M_C: return F_A_M_C;
                        F_A_M_C:   return A_M_C;
                        A_M_C:     return M_C;
                        M_C:       return CEP;
                        CEP:       return ENERGY;
                        default:   return IDLE;
                endcase
        endfunction

        always_comb begin
                state_nxt = state;
                active    = 1'b0;
                run       = 1'b0;
                len       = LEN_W'(WAIT_LEN);
                case (state)
                        IDLE, FINISH: begin
                                if (start) begin
                                        state_nxt = PRE;
                                end
                        end
                        PRE, P_W, P_W_F, P_W_F_A, P_W_F_A_M: begin
                                active    = 1'b1;
                                state_nxt = WAIT_FILL;
                        end
                        FULL: begin
                                active    = 1'b1;
                                state_nxt = WAIT_LOOP;
                        end
                        W_F_A_M_C, F_A_M_C, A_M_C, M_C: begin
                                active    = 1'b1;
                                state_nxt = WAIT_DRAIN;
                        end
                        CEP: begin
                                active    = 1'b1;
                                state_nxt = WAIT_CEP;
                        end
                        WAIT_FILL, WAIT_LOOP, WAIT_DRAIN, WAIT_CEP: begin
                                run = 1'b1;
                                if (last) begin
                                        state_nxt = resume;
                                end
                        end
                        BRANCH: begin
                                state_nxt = final_frame ? W_F_A_M_C : NEXT_FRAME;
                        end
                        NEXT_FRAME: begin
                                state_nxt = FULL;
                        end
                        ENERGY: begin
                                run = 1'b1;
                                len = LEN_W'(ENERGY_LEN);
                                if (last) begin
                                        state_nxt = DELTA;
                                end
                        end
                        DELTA: begin
                                run = 1'b1;
                                len = LEN_W'(DELTA_LEN);
                                if (last) begin
                                        state_nxt = DELTA2;
                                end
                        end
                        DELTA2: begin
                                run = 1'b1;
                                len = LEN_W'(DELTA2_LEN);
                                if (last) begin
                                        state_nxt = FINISH;
                                end
                        end
                        default: begin
                                state_nxt = IDLE;
                        end
                endcase
        end

        assign clear   = (state == PRE);        // Frame index restarts with each run
        assign advance = (state == NEXT_FRAME);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state  <= IDLE;
                        resume <= IDLE;
                end else begin
                        state <= state_nxt;
                        if (active) begin
                                resume <= follow(state);
                        end
                end
        end

endmodule

// File: src/stage_decoder.sv
module stage_decoder import mfcc_pkg::*; (
        input  seq_state_e  state,
        output logic        preem_en,
        output logic        window_en,
        output logic        fft_en,
        output logic        amp_en,
        output logic        mel_en,
        output logic        cep_en,
        output logic        delta_en,
        output logic        delta2_en,
        output logic        energy_copy_en,
        output logic        pw_swap,
        output logic        wf_swap,
        output logic        fa_swap,
        output logic        am_swap,
        output logic        mc_swap,
        output result_sel_e result_sel,
        output logic        done
);

        logic [5:0] stage_mask;         // {cep, mel, amp, fft, window, preem}

        always_comb begin
                case (state)
                        PRE:       stage_mask = 6'b000001;
                        P_W:       stage_mask = 6'b000011;
                        P_W_F:     stage_mask = 6'b000111;
                        P_W_F_A:   stage_mask = 6'b001111;
                        P_W_F_A_M: stage_mask = 6'b011111;
                        FULL:      stage_mask = 6'b111111;
                        W_F_A_M_C: stage_mask = 6'b111110;
                        F_A_M_C:   stage_mask = 6'b111100;
                        A_M_C:     stage_mask = 6'b111000;
                        M_C:       stage_mask = 6'b110000;
                        CEP:       stage_mask = 6'b100000;
                        default:   stage_mask = 6'b000000;
                endcase
        end

        assign preem_en  = stage_mask[0];
        assign window_en = stage_mask[1];
        assign fft_en    = stage_mask[2];
        assign amp_en    = stage_mask[3];
        assign mel_en    = stage_mask[4];
        assign cep_en    = stage_mask[5];

        // A boundary swaps when the stage after it runs
        assign pw_swap = stage_mask[1];
        assign wf_swap = stage_mask[2];
        assign fa_swap = stage_mask[3];
        assign am_swap = stage_mask[4];
        assign mc_swap = stage_mask[5];

        always_comb begin
                case (state)
                        FULL, CEP, WAIT_LOOP, WAIT_DRAIN, WAIT_CEP: result_sel = RES_CEP;
                        ENERGY:  result_sel = RES_ENERGY;
                        DELTA:   result_sel = RES_DELTA;
                        DELTA2:  result_sel = RES_DELTA2;
                        default: result_sel = RES_NONE;
                endcase
        end

        assign energy_copy_en = (state == ENERGY);
        assign delta_en       = (state == DELTA);
        assign delta2_en      = (state == DELTA2);
        assign done           = (state == FINISH);     // Held until the next start

endmodule

// File: src/step_timer.sv
module step_timer import mfcc_pkg::*; #(
        parameter int LEN_W = CNT_W
) (
        input  logic             clk,
        input  logic             rst_n,
        input  logic             run,
        input  logic [LEN_W-1:0] len,
        output logic             last
);

        logic [LEN_W-1:0] count;

        // Final cycle of a timed state of length len
        assign last = run && (count == len - 1'b1);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        count <= '0;
                end else if (!run || last) begin
                        count <= '0;                    // Next timed state starts from zero
                end else begin
                        count <= count + 1'b1;
                end
        end

endmodule

// File: tb/mfcc_ctrl_model.sv
module mfcc_ctrl_model import mfcc_pkg::*; #(
        parameter int WAIT_LEN   = DEF_WAIT_LEN,
        parameter int ENERGY_LEN = DEF_ENERGY_LEN,
        parameter int DELTA_LEN  = DEF_DELTA_LEN,
        parameter int DELTA2_LEN = DEF_DELTA2_LEN,
        parameter int NUM_FRAMES = DEF_NUM_FRAMES
) (
        input  logic        clk,
        input  logic        rst_n,
        input  logic        start,
        output logic [17:0] exp_vec      // Same packing as the testbench's DUT vector
);

        timeunit 1ns;
        timeprecision 100ps;

        seq_state_e st;
        seq_state_e back;               // Step that follows the current wait
        int         ticks;
        int         frame;

        // Cycles spent in a state before it moves on
        function automatic int dwell(seq_state_e s);
                case (s)
                        WAIT_FILL, WAIT_LOOP, WAIT_DRAIN, WAIT_CEP: return WAIT_LEN;
                        ENERGY:  return ENERGY_LEN;
                        DELTA:   return DELTA_LEN;
                        DELTA2:  return DELTA2_LEN;
                        default: return 1;
                endcase
        endfunction

        function automatic logic [17:0] decode(seq_state_e s);
                logic [5:0]  stg;
                result_sel_e sel;
                stg[0] = s inside {PRE, P_W, P_W_F, P_W_F_A, P_W_F_A_M, FULL};
                stg[1] = s inside {P_W, P_W_F, P_W_F_A, P_W_F_A_M, FULL, W_F_A_M_C};
                stg[2] = s inside {P_W_F, P_W_F_A, P_W_F_A_M, FULL, W_F_A_M_C, F_A_M_C};
                stg[3] = s inside {P_W_F_A, P_W_F_A_M, FULL, W_F_A_M_C, F_A_M_C, A_M_C};
                stg[4] = s inside {P_W_F_A_M, FULL, W_F_A_M_C, F_A_M_C, A_M_C, M_C};
                stg[5] = s inside {FULL, W_F_A_M_C, F_A_M_C, A_M_C, M_C, CEP};
                if (s inside {FULL, CEP, WAIT_LOOP, WAIT_DRAIN, WAIT_CEP}) begin
                        sel = RES_CEP;
                end else if (s == ENERGY) begin
                        sel = RES_ENERGY;
                end else if (s == DELTA) begin
                        sel = RES_DELTA;
                end else if (s == DELTA2) begin
                        sel = RES_DELTA2;
                end else begin
                        sel = RES_NONE;
                end
                // Swap strobes follow the downstream stage of each boundary
                return {stg, stg[5:1], s == ENERGY, s == DELTA, s == DELTA2, sel, s == FINISH};
        endfunction

        assign exp_vec = decode(st);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        st    <= IDLE;
                        back  <= IDLE;
                        ticks <= 0;
                        frame <= 0;
                end else if (ticks + 1 < dwell(st)) begin
                        ticks <= ticks + 1;
                end else begin
                        ticks <= 0;
                        case (st)
                                IDLE, FINISH: st <= start ? PRE : st;
                                PRE: begin
                                        st    <= WAIT_FILL;
                                        back  <= P_W;
                                        frame <= 0;
                                end
                                P_W: begin
                                        st   <= WAIT_FILL;
                                        back <= P_W_F;
                                end
                                P_W_F: begin
                                        st   <= WAIT_FILL;
                                        back <= P_W_F_A;
                                end
                                P_W_F_A: begin
                                        st   <= WAIT_FILL;
                                        back <= P_W_F_A_M;
                                end
                                P_W_F_A_M: begin
                                        st   <= WAIT_FILL;
                                        back <= FULL;
                                end
                                FULL: begin
                                        st   <= WAIT_LOOP;
                                        back <= BRANCH;
                                end
                                BRANCH:    st <= (frame == NUM_FRAMES - 1) ? W_F_A_M_C : NEXT_FRAME;
                                NEXT_FRAME: begin
                                        st    <= FULL;
                                        frame <= frame + 1;
                                end
                                W_F_A_M_C: begin
                                        st   <= WAIT_DRAIN;
                                        back <= F_A_M_C;
                                end
                                F_A_M_C: begin
                                        st   <= WAIT_DRAIN;
                                        back <= A_M_C;
                                end
                                A_M_C: begin
                                        st   <= WAIT_DRAIN;
                                        back <= M_C;
                                end
                                M_C: begin
                                        st   <= WAIT_DRAIN;
                                        back <= CEP;
                                end
                                CEP: begin
                                        st   <= WAIT_CEP;
                                        back <= ENERGY;
                                end
                                WAIT_FILL, WAIT_LOOP, WAIT_DRAIN, WAIT_CEP: st <= back;
                                ENERGY:    st <= DELTA;
                                DELTA:     st <= DELTA2;
                                DELTA2:    st <= FINISH;
                                default:   st <= IDLE;
                        endcase
                end
        end

endmodule

// File: tb/tb_mfcc_ctrl.sv
module tb_mfcc_ctrl import mfcc_pkg::*;;

        timeunit 1ns;
        timeprecision 100ps;

        localparam int          WAIT_LEN    = 6;
        localparam int          ENERGY_LEN  = 3;
        localparam int          DELTA_LEN   = 5;
        localparam int          DELTA2_LEN  = 4;
        localparam int          NUM_FRAMES  = 3;
        localparam int          NUM_RUNS    = 3;
        localparam int          MAX_GAP     = 20;
        localparam int          CLK_PERIOD  = 10;
        localparam int unsigned SEED        = 32'h1602547e;
        // Cycles from the cycle that presents start to the first cycle with done high
        localparam int LATENCY = (9 + NUM_FRAMES) * (1 + WAIT_LEN) + 2 * NUM_FRAMES + 1
                                 + WAIT_LEN + ENERGY_LEN + DELTA_LEN + DELTA2_LEN;
        localparam int WATCHDOG_NS = 4 * NUM_RUNS * (LATENCY + 2 * MAX_GAP) * CLK_PERIOD;

        logic        clk;
        logic        rst_n;
        logic        start;
        logic        preem_en, window_en, fft_en, amp_en, mel_en, cep_en;
        logic        delta_en, delta2_en, energy_copy_en;
        logic        pw_swap, wf_swap, fa_swap, am_swap, mc_swap;
        result_sel_e result_sel;
        logic        done;
        logic [17:0] dut_vec;
        logic [17:0] exp_vec;
        int          checks = 0;
        int          errors = 0;
        int          tests = 0;
        int          tests_failed = 0;

        assign dut_vec = {cep_en, mel_en, amp_en, fft_en, window_en, preem_en,
                          mc_swap, am_swap, fa_swap, wf_swap, pw_swap,
                          energy_copy_en, delta_en, delta2_en, result_sel, done};

        mfcc_ctrl_top #(
                .WAIT_LEN   (WAIT_LEN),
                .DELTA_LEN  (DELTA_LEN),
                .DELTA2_LEN (DELTA2_LEN),
                .ENERGY_LEN (ENERGY_LEN),
                .NUM_FRAMES (NUM_FRAMES)
        ) i_dut (
                .clk            (clk),
                .rst_n          (rst_n),
                .start          (start),
                .preem_en       (preem_en),
                .window_en      (window_en),
                .fft_en         (fft_en),
                .amp_en         (amp_en),
                .mel_en         (mel_en),
                .cep_en         (cep_en),
                .delta_en       (delta_en),
                .delta2_en      (delta2_en),
                .energy_copy_en (energy_copy_en),
                .pw_swap        (pw_swap),
                .wf_swap        (wf_swap),
                .fa_swap        (fa_swap),
                .am_swap        (am_swap),
                .mc_swap        (mc_swap),
                .result_sel     (result_sel),
                .done           (done)
        );

        mfcc_ctrl_model #(
                .WAIT_LEN   (WAIT_LEN),
                .ENERGY_LEN (ENERGY_LEN),
                .DELTA_LEN  (DELTA_LEN),
                .DELTA2_LEN (DELTA2_LEN),
                .NUM_FRAMES (NUM_FRAMES)
        ) i_model (
                .clk     (clk),
                .rst_n   (rst_n),
                .start   (start),
                .exp_vec (exp_vec)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
                end
        endtask

        task automatic compare_outputs(input string name);
                check_value({name, " outputs"}, 32'(exp_vec), 32'(dut_vec));
        endtask

        task automatic close_test(input string name, input int err_before);
                tests++;
                if (errors > err_before) begin
                        tests_failed++;
                end
                $display("test %s finished, %0d errors", name, errors - err_before);
        endtask

        // Nothing may move in IDLE while start stays low
        task automatic idle_test(input string name);
                int gap;
                int err_before;
                err_before = errors;
                gap = $urandom_range(5, MAX_GAP);
                repeat (gap) begin
                        @(negedge clk);
                        compare_outputs(name);
                        check_value({name, " all low"}, 32'd0, 32'(dut_vec));
                end
                close_test(name, err_before);
        endtask

        task automatic run_test(input string name);
                int cycles;
                int preem_cnt;
                int cep_cnt;
                int energy_cnt;
                int delta_cnt;
                int delta2_cnt;
                int gap;
                int err_before;
                err_before = errors;
                cycles     = 0;
                preem_cnt  = 0;
                cep_cnt    = 0;
                energy_cnt = 0;
                delta_cnt  = 0;
                delta2_cnt = 0;
                start = 1'b1;                   // Taken on the next rising edge
                do begin
                        @(negedge clk);
                        start = 1'b0;
                        cycles++;
                        compare_outputs(name);
                        preem_cnt  += int'(preem_en);
                        cep_cnt    += int'(cep_en);
                        energy_cnt += int'(energy_copy_en);
                        delta_cnt  += int'(delta_en);
                        delta2_cnt += int'(delta2_en);
                        if (done !== 1'b1) begin
                                start = ($urandom_range(0, 7) == 0);    // Stray pulse mid run
                        end
                end while (done !== 1'b1);
                check_value({name, " latency"}, LATENCY, cycles);
                check_value({name, " preem cycles"}, NUM_FRAMES + 5, preem_cnt);
                check_value({name, " cep cycles"}, NUM_FRAMES + 5, cep_cnt);
                check_value({name, " energy cycles"}, ENERGY_LEN, energy_cnt);
                check_value({name, " delta cycles"}, DELTA_LEN, delta_cnt);
                check_value({name, " delta2 cycles"}, DELTA2_LEN, delta2_cnt);
                gap = $urandom_range(2, MAX_GAP);
                repeat (gap) begin
                        @(negedge clk);
                        compare_outputs(name);
                        check_value({name, " done held"}, 32'd1, 32'(done));
                end
                close_test(name, err_before);
        endtask

        initial begin
                void'($urandom(SEED));
                rst_n = 1'b0;
                start = 1'b0;
                repeat (3) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                idle_test("reset_idle");
                for (int r = 0; r < NUM_RUNS; r++) begin
                        run_test($sformatf("run_%0d", r));
                end
                $display("tests %0d, failed %0d, checks %0d, errors %0d",
                         tests, tests_failed, checks, errors);
                if (errors == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

        initial begin
                #(WATCHDOG_NS);
                $display("Timeout after %0d ns, done never came", WATCHDOG_NS);
                $display("Checks failed");
                $finish;
        end

endmodule

// File: vlog.f
src/mfcc_pkg.sv
src/step_timer.sv
src/frame_counter.sv
src/mfcc_sequencer.sv
src/stage_decoder.sv
src/mfcc_ctrl_top.sv
tb/mfcc_ctrl_model.sv
tb/tb_mfcc_ctrl.sv
